//--- list.f
+incdir+verilog
verilog/lce_pkg.sv
verilog/mem_link_pkg.sv
verilog/tile_cfg_regs.sv
verilog/lce_req_arbiter.sv
verilog/mem_link_master.sv
verilog/tile_top.sv
tests/tile_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the tile testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module tile_tb -f list.f

./obj_dir/Vtile_tb > sim.log
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
   exit 0
fi

echo "Simulation reported failures, see sim.log"
exit 1

//--- tests/tile_tb.sv
// Testbench for the memory-facing tile
// Freeze gating, packet build, fairness, back-pressure, response steering, refreeze
// Reference command model, monitor with typed compare tasks, watchdog

`timescale 1ns/1ns

`include "tile_macros.svh"

module tile_tb;

   localparam logic [31:0] SEED = 32'he1f6;
   localparam int FAIR_PER_LCE = 8;
   localparam int BP_PER_LCE = 24;
   localparam int REFREEZE_PER_LCE = 3;
   localparam int NUM_TXN = 2 * (FAIR_PER_LCE + BP_PER_LCE + REFREEZE_PER_LCE);
   localparam int TIMEOUT_CYCLES = NUM_TXN * 40 + 200;

   localparam mem_link_pkg::cord_t MY_CORD    = 8'h21;
   localparam mem_link_pkg::cord_t DRAM_CORD  = 8'h03;
   localparam mem_link_pkg::cord_t CLINT_CORD = 8'h40;

   logic                            clk = 1'b0;
   logic                            reset;
   logic                            cfg_w_v;
   logic [`TILE_CFG_ADDR_WIDTH-1:0] cfg_addr;
   logic [`TILE_CFG_DATA_WIDTH-1:0] cfg_data;
   logic [1:0]                      lce_req_v;
   lce_pkg::lce_req_s [1:0]         lce_req;
   logic [1:0]                      lce_req_ready;
   logic [1:0]                      lce_resp_v;
   lce_pkg::lce_resp_s [1:0]        lce_resp;
   logic [1:0]                      lce_resp_ready;
   logic                            mem_cmd_v;
   mem_link_pkg::mem_pkt_s          mem_cmd;
   logic                            mem_cmd_ready;
   logic                            mem_resp_v;
   mem_link_pkg::mem_pkt_s          mem_resp;
   logic                            mem_resp_ready;

   lce_pkg::lce_req_s      req_q [2][$];
   mem_link_pkg::mem_pkt_s exp_q [$];
   lce_pkg::lce_id_t       seen_ids [$];
   logic [31:0]            main_rng;
   logic [31:0]            drv_rng;
   logic                   rand_valid;
   logic [1:0]             ready_mode;
   logic                   mon_en;
   logic [1:0]             acc;
   logic                   held_r;
   mem_link_pkg::mem_pkt_s held_pkt;
   int                     cmd_errors;
   int                     resp_errors;
   int                     ctrl_errors;

   tile_top UUT
     (.clk_i(clk)
      ,.reset_i(reset)
      ,.cfg_w_v_i(cfg_w_v)
      ,.cfg_addr_i(cfg_addr)
      ,.cfg_data_i(cfg_data)
      ,.my_cord_i(MY_CORD)
      ,.dram_cord_i(DRAM_CORD)
      ,.clint_cord_i(CLINT_CORD)
      ,.lce_req_v_i(lce_req_v)
      ,.lce_req_i(lce_req)
      ,.lce_req_ready_o(lce_req_ready)
      ,.lce_resp_v_o(lce_resp_v)
      ,.lce_resp_o(lce_resp)
      ,.lce_resp_ready_i(lce_resp_ready)
      ,.mem_cmd_v_o(mem_cmd_v)
      ,.mem_cmd_o(mem_cmd)
      ,.mem_cmd_ready_i(mem_cmd_ready)
      ,.mem_resp_v_i(mem_resp_v)
      ,.mem_resp_i(mem_resp)
      ,.mem_resp_ready_o(mem_resp_ready)
      );

   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Expected command packet for a request
   function automatic mem_link_pkg::mem_pkt_s expected_cmd
     (input lce_pkg::lce_req_s req, input lce_pkg::lce_id_t id,
      input mem_link_pkg::cord_t my_cord, input mem_link_pkg::cord_t dram_cord,
      input mem_link_pkg::cord_t clint_cord);
      mem_link_pkg::mem_pkt_s pkt;
      logic [31:0]            offset;
      // Below the base the offset wraps to a large value
      offset = req.paddr - `TILE_CLINT_BASE;
      pkt.dest_cord = (offset < `TILE_CLINT_SIZE) ? clint_cord : dram_cord;
      pkt.src_cord = my_cord;
      pkt.lce_id = id;
      pkt.opcode = req.opcode;
      pkt.paddr = req.paddr;
      pkt.data = req.data;
      return pkt;
   endfunction

   task automatic check_cmd(input mem_link_pkg::mem_pkt_s got,
                            input mem_link_pkg::mem_pkt_s exp, input string what);
      if (got !== exp)
      begin
         cmd_errors++;
         $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_resp(input lce_pkg::lce_resp_s got,
                             input lce_pkg::lce_resp_s exp, input string what);
      if (got !== exp)
      begin
         resp_errors++;
         $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_id(input lce_pkg::lce_id_t got, input lce_pkg::lce_id_t exp,
                           input string what);
      if (got !== exp)
      begin
         ctrl_errors++;
         $display("FAILED at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         ctrl_errors++;
         $display("FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   // Addresses cluster at both edges of the CLINT window
   task automatic make_req(output lce_pkg::lce_req_s req);
      logic [31:0] r;
      main_rng = xorshift(main_rng);
      r = main_rng;
      req.opcode = lce_pkg::lce_opcode_e'(r[1:0]);
      case (r[4:2])
         3'd0: req.paddr = `TILE_CLINT_BASE - 32'd1;
         3'd1: req.paddr = `TILE_CLINT_BASE;
         3'd2: req.paddr = `TILE_CLINT_BASE + `TILE_CLINT_SIZE - 32'd1;
         3'd3: req.paddr = `TILE_CLINT_BASE + `TILE_CLINT_SIZE;
         3'd4: req.paddr = `TILE_CLINT_BASE + (r & (`TILE_CLINT_SIZE - 32'd1));
         default: req.paddr = xorshift(r);
      endcase
      main_rng = xorshift(main_rng);
      req.data[63:32] = main_rng;
      main_rng = xorshift(main_rng);
      req.data[31:0] = main_rng;
   endtask

   task automatic load_reqs(input int n);
      lce_pkg::lce_req_s req;
      @(posedge clk);
      for (int k = 0; k < n; k++)
         for (int i = 0; i < 2; i++)
         begin
            make_req(req);
            req_q[i].push_back(req);
         end
   endtask

   task automatic cfg_write(input logic [`TILE_CFG_ADDR_WIDTH-1:0] addr,
                            input logic [`TILE_CFG_DATA_WIDTH-1:0] data);
      @(negedge clk);
      cfg_w_v = 1'b1;
      cfg_addr = addr;
      cfg_data = data;
      @(negedge clk);
      cfg_w_v = 1'b0;
   endtask

   task automatic expect_no_accept(input int cycles, input string what);
      repeat (cycles)
      begin
         @(negedge clk);
         #1;
         check_bit(|lce_req_ready, 1'b0, what);
      end
   endtask

   task automatic wait_drained();
      do
         @(posedge clk);
      while (req_q[0].size() + req_q[1].size() + exp_q.size() != 0);
   endtask

   // Requests and link ready, changed on the falling edge
   initial
   begin : drive_requests
      lce_req_v = '0;
      lce_req = '0;
      mem_cmd_ready = 1'b0;
      acc = '0;
      drv_rng = ~SEED;
      forever
      begin
         @(negedge clk);
         drv_rng = xorshift(drv_rng);
         for (int i = 0; i < 2; i++)
         begin
            if (acc[i])
               void'(req_q[i].pop_front());
            if (req_q[i].size() == 0)
            begin
               lce_req_v[i] = 1'b0;
               lce_req[i] = '0;
            end
            else
            begin
               // A raised valid stays up until accepted
               lce_req_v[i] = !rand_valid || (lce_req_v[i] && !acc[i]) || drv_rng[i];
               lce_req[i] = req_q[i][0];
            end
         end
         mem_cmd_ready = (ready_mode == 2'd2) ? drv_rng[4] : ready_mode[0];
         #1;
         acc = lce_req_v & lce_req_ready;
      end
   end

   initial
   begin : monitor
      lce_pkg::lce_id_t   rid;
      lce_pkg::lce_resp_s exp_resp;
      held_r = 1'b0;
      held_pkt = '0;
      forever
      begin
         @(negedge clk);
         #1;
         if (mon_en)
         begin
            if (held_r)
            begin
               check_bit(mem_cmd_v, 1'b1, "held command dropped its valid");
               check_cmd(mem_cmd, held_pkt, "held command changed");
            end
            check_bit(lce_req_ready != 2'b11, 1'b1, "ready to both engines");
            if (mem_cmd_v && mem_cmd_ready)
            begin
               if (exp_q.size() == 0)
               begin
                  ctrl_errors++;
                  $display("FAILED at %0t ns: command on the link with no accepted request",
                           $time);
               end
               else
                  check_cmd(mem_cmd, exp_q.pop_front(), "command packet");
               seen_ids.push_back(mem_cmd.lce_id);
            end
            for (int i = 0; i < 2; i++)
               if (lce_req_v[i] && lce_req_ready[i])
                  exp_q.push_back(expected_cmd(lce_req[i], lce_pkg::lce_id_t'(i),
                                               MY_CORD, DRAM_CORD, CLINT_CORD));
            held_r = mem_cmd_v && !mem_cmd_ready;
            held_pkt = mem_cmd;
            if (mem_resp_v)
            begin
               rid = mem_resp.lce_id;
               exp_resp.opcode = mem_resp.opcode;
               exp_resp.paddr = mem_resp.paddr;
               exp_resp.data = mem_resp.data;
               check_bit(lce_resp_v[rid], 1'b1, "response valid at target engine");
               check_bit(lce_resp_v[~rid], 1'b0, "response valid at other engine");
               check_resp(lce_resp[rid], exp_resp, "response payload");
               check_bit(mem_resp_ready, lce_resp_ready[rid], "response link ready");
            end
            else
               check_bit(|lce_resp_v, 1'b0, "response valid with idle link");
         end
      end
   end

   initial
   begin : watchdog
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
   end

   initial
   begin : run_tests
      int           total;
      logic [127:0] raw;
      reset = 1'b1;
      cfg_w_v = 1'b0;
      cfg_addr = '0;
      cfg_data = '0;
      lce_resp_ready = '0;
      mem_resp_v = 1'b0;
      mem_resp = '0;
      rand_valid = 1'b0;
      ready_mode = 2'd1;
      mon_en = 1'b0;
      main_rng = SEED;
      cmd_errors = 0;
      resp_errors = 0;
      ctrl_errors = 0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      mon_en = 1'b1;

      // Frozen out of reset
      load_reqs(FAIR_PER_LCE);
      expect_no_accept(6, "accept while frozen after reset");
      cfg_write(8'h05, 32'h0);
      expect_no_accept(6, "accept after write to another config address");
      cfg_write(`TILE_CFG_FREEZE_ADDR, 32'h0);

      // Both engines always valid, link always ready
      wait_drained();
      check_bit(seen_ids.size() == 2 * FAIR_PER_LCE, 1'b1, "fairness packet count");
      for (int k = 0; k < seen_ids.size(); k++)
         check_id(seen_ids[k], lce_pkg::lce_id_t'(k % 2), "round-robin order");

      // Random valids and link ready, random responses alongside
      rand_valid = 1'b1;
      ready_mode = 2'd2;
      load_reqs(BP_PER_LCE);
      while (req_q[0].size() + req_q[1].size() + exp_q.size() != 0)
      begin
         @(negedge clk);
         main_rng = xorshift(main_rng);
         mem_resp_v = main_rng[0];
         lce_resp_ready = main_rng[2:1];
         for (int w = 0; w < 4; w++)
         begin
            main_rng = xorshift(main_rng);
            raw[w*32 +: 32] = main_rng;
         end
         mem_resp = mem_link_pkg::mem_pkt_s'(raw[114:0]);
         @(posedge clk);
      end
      @(negedge clk);
      mem_resp_v = 1'b0;

      // One packet parked in the buffer, then refreeze
      @(posedge clk);
      rand_valid = 1'b0;
      ready_mode = 2'd0;
      load_reqs(REFREEZE_PER_LCE);
      do
      begin
         @(negedge clk);
         #1;
      end
      while (!mem_cmd_v);
      cfg_write(`TILE_CFG_FREEZE_ADDR, 32'h1);
      @(posedge clk);
      ready_mode = 2'd1;
      expect_no_accept(8, "accept after refreeze");
      check_bit(mem_cmd_v, 1'b0, "link still valid after refreeze drain");

      @(posedge clk);
      check_bit(exp_q.size() == 0, 1'b1, "accepted requests all sent on the link");
      total = cmd_errors + resp_errors + ctrl_errors;
      $display("Error counts: command %0d, response %0d, control %0d",
               cmd_errors, resp_errors, ctrl_errors);
      if (total == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- verilog/lce_pkg.sv
// Cache-engine side types
// Opcodes, request and response structs, engine index

`include "tile_macros.svh"

package lce_pkg;

   typedef enum logic [1:0]
   {
      e_lce_rd    = 2'b00,
      e_lce_wr    = 2'b01,
      e_lce_uc_rd = 2'b10,
      e_lce_uc_wr = 2'b11
   } lce_opcode_e;

   // Engine index, 0 for the I-side and 1 for the D-side
   typedef logic [0:0] lce_id_t;

   // 98 bits
   typedef struct packed
   {
      lce_opcode_e                  opcode;
      logic [`TILE_PADDR_WIDTH-1:0] paddr;
      logic [`TILE_DATA_WIDTH-1:0]  data;
   } lce_req_s;

   // 98 bits
   typedef struct packed
   {
      lce_opcode_e                  opcode;
      logic [`TILE_PADDR_WIDTH-1:0] paddr;
      logic [`TILE_DATA_WIDTH-1:0]  data;
   } lce_resp_s;

endpackage

//--- verilog/lce_req_arbiter.sv
// Round-robin arbiter for the two cache engine request ports
// Presents one granted request to the link master, nothing while frozen

`timescale 1ns/1ns

`include "tile_macros.svh"

module lce_req_arbiter
  (
   input  logic                                        clk_i
   , input  logic                                      reset_i
   , input  logic                                      freeze_i

   // Engine request ports
   , input  logic [`TILE_NUM_LCE-1:0]                  lce_req_v_i
   , input  lce_pkg::lce_req_s [`TILE_NUM_LCE-1:0]     lce_req_i
   , output logic [`TILE_NUM_LCE-1:0]                  lce_req_ready_o

   // Granted request toward the link master
   , output logic                                      arb_v_o
   , output lce_pkg::lce_req_s                         arb_req_o
   , output lce_pkg::lce_id_t                          arb_lce_id_o
   , input  logic                                      arb_ready_i
  );

   lce_pkg::lce_id_t prio_r;
   lce_pkg::lce_id_t other_id;
   lce_pkg::lce_id_t grant_id;
   logic             grant_v;
   logic             accept;

   assign other_id = ~prio_r;

   // Engine at prio_r wins a tie
   always_comb
   begin
      grant_v  = 1'b0;
      grant_id = prio_r;
      if (!freeze_i)
      begin
         if (lce_req_v_i[prio_r])
         begin
            grant_v  = 1'b1;
            grant_id = prio_r;
         end
         else if (lce_req_v_i[other_id])
         begin
            grant_v  = 1'b1;
            grant_id = other_id;
         end
      end
   end

   assign accept = grant_v && arb_ready_i;

   for (genvar i = 0; i < `TILE_NUM_LCE; i++)
   begin : g_ready
      assign lce_req_ready_o[i] = accept && (grant_id == lce_pkg::lce_id_t'(i));
   end

   assign arb_v_o      = grant_v;
   assign arb_req_o    = lce_req_i[grant_id];
   assign arb_lce_id_o = grant_id;

   // Priority passes to the engine not just served
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         prio_r <= '0;
      else if (accept)
         prio_r <= ~grant_id;
   end

endmodule

//--- verilog/mem_link_master.sv
// Memory link master
// Address map to CLINT or DRAM coordinate, command packet build
// One-entry command buffer and response steering by LCE id

`timescale 1ns/1ns

`include "tile_macros.svh"

module mem_link_master
  (
   input  logic                                        clk_i
   , input  logic                                      reset_i

   , input  mem_link_pkg::cord_t                       my_cord_i
   , input  mem_link_pkg::cord_t                       dram_cord_i
   , input  mem_link_pkg::cord_t                       clint_cord_i

   // Granted request from the arbiter
   , input  logic                                      arb_v_i
   , input  lce_pkg::lce_req_s                         arb_req_i
   , input  lce_pkg::lce_id_t                          arb_lce_id_i
   , output logic                                      arb_ready_o

   // Command link
   , output logic                                      mem_cmd_v_o
   , output mem_link_pkg::mem_pkt_s                    mem_cmd_o
   , input  logic                                      mem_cmd_ready_i

   // Response link
   , input  logic                                      mem_resp_v_i
   , input  mem_link_pkg::mem_pkt_s                    mem_resp_i
   , output logic                                      mem_resp_ready_o

   // Responses back to the engines
   , output logic [`TILE_NUM_LCE-1:0]                  lce_resp_v_o
   , output lce_pkg::lce_resp_s [`TILE_NUM_LCE-1:0]    lce_resp_o
   , input  logic [`TILE_NUM_LCE-1:0]                  lce_resp_ready_i
  );

   logic                   in_clint;
   mem_link_pkg::cord_t    dest_cord;
   mem_link_pkg::mem_pkt_s cmd_pkt;
   mem_link_pkg::mem_pkt_s cmd_pkt_r;
   logic                   cmd_full_r;
   logic                   cmd_load;
   lce_pkg::lce_resp_s     resp_payload;

   // Half-open CLINT window
   assign in_clint = (arb_req_i.paddr >= `TILE_CLINT_BASE)
                  && (arb_req_i.paddr < (`TILE_CLINT_BASE + `TILE_CLINT_SIZE));

   assign dest_cord = in_clint ? clint_cord_i : dram_cord_i;

   always_comb
   begin
      cmd_pkt.dest_cord = dest_cord;
      cmd_pkt.src_cord  = my_cord_i;
      cmd_pkt.lce_id    = arb_lce_id_i;
      cmd_pkt.opcode    = arb_req_i.opcode;
      cmd_pkt.paddr     = arb_req_i.paddr;
      cmd_pkt.data      = arb_req_i.data;
   end

   // Room when empty or draining on this edge
   assign arb_ready_o = !cmd_full_r || mem_cmd_ready_i;
   assign cmd_load    = arb_v_i && arb_ready_o;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         cmd_full_r <= 1'b0;
      else if (cmd_load)
         cmd_full_r <= 1'b1;
      else if (mem_cmd_ready_i)
         cmd_full_r <= 1'b0;
   end

   always_ff @(posedge clk_i)
   begin
      if (cmd_load)
         cmd_pkt_r <= cmd_pkt;
   end

   assign mem_cmd_v_o = cmd_full_r;
   assign mem_cmd_o   = cmd_pkt_r;

   // Responses pass straight through, only the valid is steered
   always_comb
   begin
      resp_payload.opcode = mem_resp_i.opcode;
      resp_payload.paddr  = mem_resp_i.paddr;
      resp_payload.data   = mem_resp_i.data;
   end

   for (genvar i = 0; i < `TILE_NUM_LCE; i++)
   begin : g_resp
      assign lce_resp_v_o[i] = mem_resp_v_i
                            && (mem_resp_i.lce_id == lce_pkg::lce_id_t'(i));
      assign lce_resp_o[i]   = resp_payload;
   end

   assign mem_resp_ready_o = lce_resp_ready_i[mem_resp_i.lce_id];

endmodule

//--- verilog/mem_link_pkg.sv
// Memory-network side types
// Coordinate type and the single-flit link packet

`include "tile_macros.svh"

package mem_link_pkg;

   typedef logic [`TILE_CORD_WIDTH-1:0] cord_t;

   // 115 bits, used for both the command and the response link
   typedef struct packed
   {
      cord_t                        dest_cord;
      cord_t                        src_cord;
      lce_pkg::lce_id_t             lce_id;
      lce_pkg::lce_opcode_e         opcode;
      logic [`TILE_PADDR_WIDTH-1:0] paddr;
      logic [`TILE_DATA_WIDTH-1:0]  data;
   } mem_pkt_s;

endpackage

//--- verilog/tile_cfg_regs.sv
// Tile configuration registers
// Freeze register written over the config channel
// Registered copy of the external reset for the rest of the tile

`timescale 1ns/1ns

`include "tile_macros.svh"

module tile_cfg_regs
  (
   input  logic                            clk_i
   , input  logic                          reset_i

   , input  logic                          cfg_w_v_i
   , input  logic [`TILE_CFG_ADDR_WIDTH-1:0] cfg_addr_i
   , input  logic [`TILE_CFG_DATA_WIDTH-1:0] cfg_data_i

   , output logic                          freeze_o
   , output logic                          reset_o
  );

   logic freeze_r;
   logic reset_r;
   logic freeze_wr;

   assign freeze_wr = cfg_w_v_i && (cfg_addr_i == `TILE_CFG_FREEZE_ADDR);

   // Tile comes out of reset frozen
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         freeze_r <= 1'b1;
      else if (freeze_wr)
         freeze_r <= cfg_data_i[0];
   end

   // One cycle behind reset_i
   always_ff @(posedge clk_i)
   begin
      reset_r <= reset_i;
   end

   assign freeze_o = freeze_r;
   assign reset_o  = reset_r;

endmodule

//--- verilog/tile_macros.svh
// Width and address-map constants for the memory-facing tile
// Config register addresses and the CLINT window

`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

// Datapath widths
`define TILE_PADDR_WIDTH 32
`define TILE_DATA_WIDTH 64
`define TILE_CORD_WIDTH 8

// Cache engines sharing the memory link
`define TILE_NUM_LCE 2

// Configuration channel
`define TILE_CFG_ADDR_WIDTH 32'd8
`define TILE_CFG_DATA_WIDTH 32'd32
`define TILE_CFG_FREEZE_ADDR 8'h02

// CLINT window in the physical address space, everything else goes to DRAM
`define TILE_CLINT_BASE 32'h0200_0000
`define TILE_CLINT_SIZE 32'h0001_0000

`endif

//--- verilog/tile_top.sv
// Memory-facing side of the two-engine tile
// Config block, request arbiter and memory link master

`timescale 1ns/1ns

`include "tile_macros.svh"

module tile_top
  (
   input  logic                                        clk_i
   , input  logic                                      reset_i

   // Config channel
   , input  logic                                      cfg_w_v_i
   , input  logic [`TILE_CFG_ADDR_WIDTH-1:0]           cfg_addr_i
   , input  logic [`TILE_CFG_DATA_WIDTH-1:0]           cfg_data_i

   , input  mem_link_pkg::cord_t                       my_cord_i
   , input  mem_link_pkg::cord_t                       dram_cord_i
   , input  mem_link_pkg::cord_t                       clint_cord_i

   // Engine requests, I-side at index 0 and D-side at index 1
   , input  logic [`TILE_NUM_LCE-1:0]                  lce_req_v_i
   , input  lce_pkg::lce_req_s [`TILE_NUM_LCE-1:0]     lce_req_i
   , output logic [`TILE_NUM_LCE-1:0]                  lce_req_ready_o

   // Engine responses
   , output logic [`TILE_NUM_LCE-1:0]                  lce_resp_v_o
   , output lce_pkg::lce_resp_s [`TILE_NUM_LCE-1:0]    lce_resp_o
   , input  logic [`TILE_NUM_LCE-1:0]                  lce_resp_ready_i

   // Command link
   , output logic                                      mem_cmd_v_o
   , output mem_link_pkg::mem_pkt_s                    mem_cmd_o
   , input  logic                                      mem_cmd_ready_i

   // Response link
   , input  logic                                      mem_resp_v_i
   , input  mem_link_pkg::mem_pkt_s                    mem_resp_i
   , output logic                                      mem_resp_ready_o
  );

   logic              freeze;
   logic              reset_r;

   logic              arb_v;
   lce_pkg::lce_req_s arb_req;
   lce_pkg::lce_id_t  arb_lce_id;
   logic              arb_ready;

   tile_cfg_regs cfg_regs
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.cfg_w_v_i(cfg_w_v_i)
      ,.cfg_addr_i(cfg_addr_i)
      ,.cfg_data_i(cfg_data_i)
      ,.freeze_o(freeze)
      ,.reset_o(reset_r)
      );

   lce_req_arbiter req_arb
     (.clk_i(clk_i)
      ,.reset_i(reset_r)
      ,.freeze_i(freeze)
      ,.lce_req_v_i(lce_req_v_i)
      ,.lce_req_i(lce_req_i)
      ,.lce_req_ready_o(lce_req_ready_o)
      ,.arb_v_o(arb_v)
      ,.arb_req_o(arb_req)
      ,.arb_lce_id_o(arb_lce_id)
      ,.arb_ready_i(arb_ready)
      );

   mem_link_master link_master
     (.clk_i(clk_i)
      ,.reset_i(reset_r)
      ,.my_cord_i(my_cord_i)
      ,.dram_cord_i(dram_cord_i)
      ,.clint_cord_i(clint_cord_i)
      ,.arb_v_i(arb_v)
      ,.arb_req_i(arb_req)
      ,.arb_lce_id_i(arb_lce_id)
      ,.arb_ready_o(arb_ready)
      ,.mem_cmd_v_o(mem_cmd_v_o)
      ,.mem_cmd_o(mem_cmd_o)
      ,.mem_cmd_ready_i(mem_cmd_ready_i)
      ,.mem_resp_v_i(mem_resp_v_i)
      ,.mem_resp_i(mem_resp_i)
      ,.mem_resp_ready_o(mem_resp_ready_o)
      ,.lce_resp_v_o(lce_resp_v_o)
      ,.lce_resp_o(lce_resp_o)
      ,.lce_resp_ready_i(lce_resp_ready_i)
      );

endmodule
